// File: Makefile
TOP = tb_mem_system

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f sources.f -o V$(TOP)

# Pass only when the simulation prints the pass message
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir

// File: bench/mem_stim.txt
# op size address data   (op: w write, r read; size: 0 B, 1 H, 2 W, 4 BU, 5 HU)
# data is the store value on writes and the expected load result on reads
r 2 80000000 00000001
w 2 10000000 deadbeef
w 2 10000004 01234567
w 2 10000008 a5a5f00f
r 2 10000000 deadbeef
r 2 10000004 01234567
r 2 10000008 a5a5f00f
# Byte and halfword stores merge into one word
w 2 10000010 00000000
w 0 10000011 000000ab
w 1 10000012 00001234
w 0 10000010 000000ff
r 2 10000010 1234abff
# Sub-word loads at every offset
r 0 10000008 0000000f
r 0 10000009 fffffff0
r 0 1000000a ffffffa5
r 0 1000000b ffffffa5
r 4 10000008 0000000f
r 4 10000009 000000f0
r 4 1000000a 000000a5
r 4 1000000b 000000a5
r 1 10000008 fffff00f
r 1 1000000a ffffa5a5
r 5 10000008 0000f00f
r 5 1000000a 0000a5a5
r 0 10000000 ffffffef
r 4 10000002 000000ad
r 1 10000002 ffffdead
r 5 10000000 0000beef
# Unmapped region, writes ignored and reads zero
w 2 40000000 cafebabe
r 2 40000000 00000000
w 2 40000004 ffffffff
w 2 40000008 00000055
r 2 10000004 01234567
# Counter reads, the data column is unused
r 2 80000010 00000000
w 2 80000008 00000048
w 0 80000008 00000069
w 2 80000008 00000021
w 2 80000008 0000000a
r 2 80000010 00000000
w 2 80000018 00000000
r 2 80000010 00000000
r 2 80000010 00000000

// File: bench/mem_system_assert.sv
`timescale 1ns/100ps

// Protocol properties of the data-memory subsystem
module mem_system_assert import lsu_pkg::*; (
  input logic                clk,
  input logic                reset,
  input logic                req_valid,
  input logic                req_write,
  input logic                rsp_valid,
  input logic [BE_WIDTH-1:0] ram_byte_en,
  input logic [7:0]          uart_tx_data,
  input logic                uart_tx_valid,
  input logic                uart_tx_ready
);

  // One response per read, exactly one cycle later
  rsp_after_read: assert property (@(posedge clk) disable iff (reset)
    (req_valid && !req_write) |=> rsp_valid)
    else $error("rsp_valid missing one cycle after a read request");

  rsp_only_for_read: assert property (@(posedge clk) disable iff (reset)
    !(req_valid && !req_write) |=> !rsp_valid)
    else $error("rsp_valid without a read request in the cycle before");

  byte_en_needs_write: assert property (@(posedge clk) disable iff (reset)
    (ram_byte_en != '0) |-> (req_valid && req_write))
    else $error("RAM byte enable active without a write request");

  // Byte held under back-pressure
  tx_held: assert property (@(posedge clk) disable iff (reset)
    (uart_tx_valid && !uart_tx_ready) |=> (uart_tx_valid && $stable(uart_tx_data)))
    else $error("uart_tx_valid or uart_tx_data changed while ready was low");

endmodule

bind mem_system mem_system_assert i_mem_system_assert (
  .clk           (clk),
  .reset         (reset),
  .req_valid     (req_valid),
  .req_write     (req_write),
  .rsp_valid     (rsp_valid),
  .ram_byte_en   (ram_byte_en),
  .uart_tx_data  (uart_tx_data),
  .uart_tx_valid (uart_tx_valid),
  .uart_tx_ready (uart_tx_ready)
);

// File: bench/tb_mem_system.sv
`timescale 1ns/100ps

module tb_mem_system import lsu_pkg::*, map_pkg::*; ();

  localparam int TX_WAIT_LIMIT = 200;  // Cycles
  localparam int DRAIN_LIMIT   = 400;

  logic              clk = 1'b0;
  logic              reset;
  logic              req_valid;
  logic              req_write;
  logic [SIZE_W-1:0] req_size;
  logic [XLEN-1:0]   req_addr;
  logic [XLEN-1:0]   req_wdata;
  logic              rsp_valid;
  logic [XLEN-1:0]   rsp_rdata;
  logic [7:0]        uart_tx_data;
  logic              uart_tx_valid;
  logic              uart_tx_ready;

  logic [XLEN-1:0] rsp_q[$];   // Expected read results, oldest first
  logic [7:0]      tx_q[$];    // Bytes still due on the transmit port
  logic [7:0]      exp_byte;
  int              checks;
  int              errors;
  int              req_count;  // Requests since reset or last clear

  mem_system #(
    .DMEM_AWIDTH (14)
  ) i_mem_system (
    .clk           (clk),
    .reset         (reset),
    .req_valid     (req_valid),
    .req_write     (req_write),
    .req_size      (req_size),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .rsp_valid     (rsp_valid),
    .rsp_rdata     (rsp_rdata),
    .uart_tx_data  (uart_tx_data),
    .uart_tx_valid (uart_tx_valid),
    .uart_tx_ready (uart_tx_ready)
  );

  always #2 clk = ~clk;

  // Random back-pressure on the transmit port
  initial begin
    uart_tx_ready = 1'b0;
    void'($urandom(32'hb5d9));
    forever begin
      @(posedge clk);
      uart_tx_ready <= ($urandom & 1) != 0;
    end
  end

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s got %08h expected %08h", $time, name, got, exp);
    end
  endtask

  // Read responses, sampled mid-cycle
  always @(negedge clk) begin
    if (!reset && rsp_valid) begin
      if (rsp_q.size() == 0) begin
        errors++;
        $display("Response at %0t with no read outstanding", $time);
      end else begin
        check_value("rsp_rdata", rsp_rdata, rsp_q.pop_front());
      end
    end
  end

  // Byte sink, valid and ready seen here hold until the next rising edge
  always @(negedge clk) begin
    if (!reset && uart_tx_valid && uart_tx_ready) begin
      if (tx_q.size() == 0) begin
        errors++;
        $display("Unexpected byte %02h on the transmit port at %0t", uart_tx_data, $time);
      end else begin
        exp_byte = tx_q.pop_front();
        check_value("uart_tx_data", XLEN'(uart_tx_data), XLEN'(exp_byte));
      end
    end
  end

  task automatic send_req(input logic write, input logic [SIZE_W-1:0] size,
                          input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wdata);
    @(posedge clk);
    req_valid <= 1'b1;
    req_write <= write;
    req_size  <= size;
    req_addr  <= addr;
    req_wdata <= wdata;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  task automatic wait_tx_free();
    int cycles;
    cycles = 0;
    idle_cycle();  // Lets a transmit write still in flight land
    @(negedge clk);
    while (uart_tx_valid && cycles < TX_WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (uart_tx_valid) begin
      errors++;
      $display("Timeout at %0t: transmit register never became free", $time);
    end
  endtask

  task automatic run_line(input logic [7:0] op, input logic [SIZE_W-1:0] size,
                          input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
    logic is_mmio;
    is_mmio = (addr[31:28] == REGION_MMIO);
    if (op == "w") begin
      if (is_mmio && addr[7:0] == MMIO_TX_DATA) begin
        wait_tx_free();
        tx_q.push_back(data[7:0]);
      end
      send_req(1'b1, size, addr, data);
      if (is_mmio && addr[7:0] == MMIO_COUNT_CLR) begin
        req_count = 0;  // Clear is not counted
      end else begin
        req_count++;
      end
    end else begin
      if (is_mmio && addr[7:0] == MMIO_COUNT) begin
        rsp_q.push_back(XLEN'(req_count));
      end else begin
        rsp_q.push_back(data);
      end
      send_req(1'b0, size, addr, data);
      req_count++;
    end
  endtask

  initial begin
    int                fd;
    int                n;
    int                cycles;
    string             line;
    logic [7:0]        op;
    logic [SIZE_W-1:0] size;
    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   data;

    reset     = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_size  = '0;
    req_addr  = '0;
    req_wdata = '0;
    checks    = 0;
    errors    = 0;
    req_count = 0;

    repeat (3) @(posedge clk);
    reset <= 1'b0;

    fd = $fopen("bench/mem_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open bench/mem_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          op = line.getc(0);
          n  = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", size, addr, data);
          if (n == 3 && (op == "w" || op == "r")) begin
            run_line(op, size, addr, data);
          end else begin
            errors++;
            $display("Malformed stimulus line: %s", line);
          end
        end
      end
      $fclose(fd);
    end
    idle_cycle();

    // Let outstanding reads and bytes drain
    cycles = 0;
    while ((rsp_q.size() != 0 || tx_q.size() != 0) && cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (rsp_q.size() != 0 || tx_q.size() != 0) begin
      errors++;
      $display("Timeout: %0d reads and %0d bytes never arrived", rsp_q.size(), tx_q.size());
    end
    if (checks == 0) begin
      errors++;
      $display("No response was checked");
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: sources.f
src/lsu_pkg.sv
src/map_pkg.sv
src/store_align.sv
src/load_extract.sv
src/data_ram.sv
src/mmio_regs.sv
src/mem_router.sv
src/mem_system.sv
bench/mem_system_assert.sv
bench/tb_mem_system.sv

// File: src/data_ram.sv
`timescale 1ns/100ps

// Single-port data RAM, byte write enables, one-cycle read
module data_ram import lsu_pkg::*; #(
  parameter int DMEM_AWIDTH = 14
) (
  input  logic                   clk,
  input  logic [DMEM_AWIDTH-1:0] addr,
  input  logic [XLEN-1:0]        wdata,
  input  logic [BE_WIDTH-1:0]    byte_en,
  output logic [XLEN-1:0]        rdata
);

  localparam int DEPTH = 2 ** DMEM_AWIDTH;

  logic [XLEN-1:0] mem [0:DEPTH-1];

  always_ff @(posedge clk) begin
    for (int i = 0; i < BE_WIDTH; i++) begin
      if (byte_en[i]) begin
        mem[addr][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
    rdata <= mem[addr];  // Old contents on a same-address write
  end

endmodule

// File: src/load_extract.sv
`timescale 1ns/100ps

// Picks the addressed byte or halfword out of a read word and extends it
module load_extract import lsu_pkg::*; (
  input  logic [SIZE_W-1:0] size,
  input  logic [1:0]        byte_off,
  input  logic [XLEN-1:0]   word,
  output logic [XLEN-1:0]   rdata
);

  logic [XLEN-1:0] shifted;

  // Addressed lane moved down to bit 0
  assign shifted = word >> {byte_off, 3'b000};

  always_comb begin
    case (size)
      SZ_B:    rdata = {{24{shifted[7]}}, shifted[7:0]};
      SZ_BU:   rdata = {24'h000000, shifted[7:0]};
      SZ_H:    rdata = {{16{shifted[15]}}, shifted[15:0]};
      SZ_HU:   rdata = {16'h0000, shifted[15:0]};
      SZ_W:    rdata = word;  // No lane select for words
      default: rdata = word;
    endcase
  end

endmodule

// File: src/lsu_pkg.sv
// Load/store access encodings and data widths
package lsu_pkg;

  // Data path
  parameter int XLEN     = 32;
  parameter int BE_WIDTH = XLEN / 8;  // One enable per byte lane

  // Access size, same encoding as funct3 of RV32 loads and stores
  parameter int SIZE_W = 3;

  parameter logic [SIZE_W-1:0] SZ_B  = 3'b000;  // Byte, sign extended
  parameter logic [SIZE_W-1:0] SZ_H  = 3'b001;  // Halfword, sign extended
  parameter logic [SIZE_W-1:0] SZ_W  = 3'b010;  // Full word
  parameter logic [SIZE_W-1:0] SZ_BU = 3'b100;  // Byte, zero extended
  parameter logic [SIZE_W-1:0] SZ_HU = 3'b101;  // Halfword, zero extended

  // Stores look at bits [1:0] only, so SB/SH/SW map onto B/H/W

endpackage

// File: src/map_pkg.sv
// Address map of the data-memory subsystem
package map_pkg;

  // Top nibble of the address selects the region
  parameter logic [3:0] REGION_DMEM = 4'h1;  // Data RAM
  parameter logic [3:0] REGION_MMIO = 4'h8;  // Register block

  // Register offsets inside the MMIO region
  parameter int MMIO_OFF_W = 8;

  parameter logic [MMIO_OFF_W-1:0] MMIO_STATUS    = 8'h00;  // Bit 0 is tx ready
  parameter logic [MMIO_OFF_W-1:0] MMIO_TX_DATA   = 8'h08;  // Transmit byte
  parameter logic [MMIO_OFF_W-1:0] MMIO_COUNT     = 8'h10;  // Request counter
  parameter logic [MMIO_OFF_W-1:0] MMIO_COUNT_CLR = 8'h18;  // Write clears counter

  // Request address, seen either as one word or split into fields.
  // The flat view feeds the register offset, the field view feeds
  // region decode, RAM indexing and lane selection.
  typedef union packed {
    logic [31:0] flat;
    struct packed {
      logic [3:0]  region;
      logic [25:0] word_idx;
      logic [1:0]  byte_off;
    } fields;
  } mem_addr_u;

endpackage

// File: src/mem_router.sv
`timescale 1ns/100ps

// Region decode on the request side, registered read return path
module mem_router import lsu_pkg::*, map_pkg::*; #(
  parameter int DMEM_AWIDTH = 14
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_valid,
  input  logic                   req_write,
  input  logic [SIZE_W-1:0]      req_size,
  input  logic [XLEN-1:0]        req_addr,
  input  logic [XLEN-1:0]        req_wdata,
  output logic                   rsp_valid,
  output logic [XLEN-1:0]        rsp_rdata,
  output logic [DMEM_AWIDTH-1:0] ram_addr,
  output logic [XLEN-1:0]        ram_wdata,
  output logic [BE_WIDTH-1:0]    ram_byte_en,
  input  logic [XLEN-1:0]        ram_rdata,
  output logic                   mmio_req,
  output logic                   mmio_we,
  output logic [MMIO_OFF_W-1:0]  mmio_offset,
  output logic [XLEN-1:0]        mmio_wdata,
  input  logic [XLEN-1:0]        mmio_rdata
);

  mem_addr_u             addr;
  logic                  wr_req;
  logic                  rd_req;
  logic [XLEN-1:0]       lane_data;
  logic [BE_WIDTH-1:0]   lane_be;
  logic [3:0]            rd_region_q;
  logic [SIZE_W-1:0]     rd_size_q;
  logic [1:0]            rd_off_q;
  logic [XLEN-1:0]       mmio_word_q;
  logic [XLEN-1:0]       sel_word;

  assign addr   = req_addr;
  assign wr_req = req_valid && req_write;
  assign rd_req = req_valid && !req_write;

  store_align i_store_align (
    .size      (req_size),
    .byte_off  (addr.fields.byte_off),
    .wdata     (req_wdata),
    .lane_data (lane_data),
    .byte_en   (lane_be)
  );

  // RAM side, enables only for writes into the RAM region
  assign ram_addr    = addr.fields.word_idx[DMEM_AWIDTH-1:0];
  assign ram_wdata   = lane_data;
  assign ram_byte_en = (wr_req && addr.fields.region == REGION_DMEM) ? lane_be : '0;

  // Register side
  assign mmio_req    = req_valid;  // Counter sees every request
  assign mmio_we     = wr_req && (addr.fields.region == REGION_MMIO);
  assign mmio_offset = addr.flat[MMIO_OFF_W-1:0];
  assign mmio_wdata  = lane_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= rd_req;
    end
  end

  // Read context travels with the RAM latency
  always_ff @(posedge clk) begin
    rd_region_q <= addr.fields.region;
    rd_size_q   <= req_size;
    rd_off_q    <= addr.fields.byte_off;
    mmio_word_q <= mmio_rdata;
  end

  always_comb begin
    case (rd_region_q)
      REGION_DMEM: sel_word = ram_rdata;
      REGION_MMIO: sel_word = mmio_word_q;
      default:     sel_word = '0;  // Unmapped reads as zero
    endcase
  end

  load_extract i_load_extract (
    .size     (rd_size_q),
    .byte_off (rd_off_q),
    .word     (sel_word),
    .rdata    (rsp_rdata)
  );

endmodule

// File: src/mem_system.sv
`timescale 1ns/100ps

// Data-memory subsystem: router, data RAM and register block
module mem_system import lsu_pkg::*, map_pkg::*; #(
  parameter int DMEM_AWIDTH = 14
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_valid,
  input  logic              req_write,
  input  logic [SIZE_W-1:0] req_size,
  input  logic [XLEN-1:0]   req_addr,
  input  logic [XLEN-1:0]   req_wdata,
  output logic              rsp_valid,
  output logic [XLEN-1:0]   rsp_rdata,
  output logic [7:0]        uart_tx_data,
  output logic              uart_tx_valid,
  input  logic              uart_tx_ready
);

  logic [DMEM_AWIDTH-1:0] ram_addr;
  logic [XLEN-1:0]        ram_wdata;
  logic [BE_WIDTH-1:0]    ram_byte_en;
  logic [XLEN-1:0]        ram_rdata;
  logic                   mmio_req;
  logic                   mmio_we;
  logic [MMIO_OFF_W-1:0]  mmio_offset;
  logic [XLEN-1:0]        mmio_wdata;
  logic [XLEN-1:0]        mmio_rdata;

  mem_router #(
    .DMEM_AWIDTH (DMEM_AWIDTH)
  ) i_mem_router (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_write   (req_write),
    .req_size    (req_size),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .rsp_valid   (rsp_valid),
    .rsp_rdata   (rsp_rdata),
    .ram_addr    (ram_addr),
    .ram_wdata   (ram_wdata),
    .ram_byte_en (ram_byte_en),
    .ram_rdata   (ram_rdata),
    .mmio_req    (mmio_req),
    .mmio_we     (mmio_we),
    .mmio_offset (mmio_offset),
    .mmio_wdata  (mmio_wdata),
    .mmio_rdata  (mmio_rdata)
  );

  data_ram #(
    .DMEM_AWIDTH (DMEM_AWIDTH)
  ) i_data_ram (
    .clk     (clk),
    .addr    (ram_addr),
    .wdata   (ram_wdata),
    .byte_en (ram_byte_en),
    .rdata   (ram_rdata)
  );

  mmio_regs i_mmio_regs (
    .clk           (clk),
    .reset         (reset),
    .req_pulse     (mmio_req),
    .reg_we        (mmio_we),
    .offset        (mmio_offset),
    .wdata         (mmio_wdata),
    .rdata         (mmio_rdata),
    .uart_tx_data  (uart_tx_data),
    .uart_tx_valid (uart_tx_valid),
    .uart_tx_ready (uart_tx_ready)
  );

endmodule

// File: src/mmio_regs.sv
`timescale 1ns/100ps

// Register block: UART transmit byte, status and request counter
module mmio_regs import lsu_pkg::*, map_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_pulse,  // One per accepted request
  input  logic                  reg_we,
  input  logic [MMIO_OFF_W-1:0] offset,
  input  logic [XLEN-1:0]       wdata,
  output logic [XLEN-1:0]       rdata,
  output logic [7:0]            uart_tx_data,
  output logic                  uart_tx_valid,
  input  logic                  uart_tx_ready
);

  logic            tx_load;
  logic            tx_fire;
  logic            count_clr;
  logic [XLEN-1:0] req_count;

  // Writes while a byte is still pending are lost
  assign tx_load   = reg_we && (offset == MMIO_TX_DATA) && !uart_tx_valid;
  assign tx_fire   = uart_tx_valid && uart_tx_ready;
  assign count_clr = reg_we && (offset == MMIO_COUNT_CLR);

  always_ff @(posedge clk) begin
    if (reset) begin
      uart_tx_valid <= 1'b0;
    end else if (tx_load) begin
      uart_tx_valid <= 1'b1;
    end else if (tx_fire) begin
      uart_tx_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (tx_load) begin
      uart_tx_data <= wdata[7:0];
    end
  end

  // Clear wins over counting, so the clear write itself is not counted
  always_ff @(posedge clk) begin
    if (reset || count_clr) begin
      req_count <= '0;
    end else if (req_pulse) begin
      req_count <= req_count + 1'b1;
    end
  end

  // Read mux, registered by the router
  always_comb begin
    case (offset)
      MMIO_STATUS: rdata = {{(XLEN-1){1'b0}}, ~uart_tx_valid};
      MMIO_COUNT:  rdata = req_count;  // Count before this request
      default:     rdata = '0;
    endcase
  end

endmodule

// File: src/store_align.sv
`timescale 1ns/100ps

// Moves store data onto its byte lane and builds the byte enables
module store_align import lsu_pkg::*; (
  input  logic [SIZE_W-1:0]   size,
  input  logic [1:0]          byte_off,
  input  logic [XLEN-1:0]     wdata,
  output logic [XLEN-1:0]     lane_data,
  output logic [BE_WIDTH-1:0] byte_en
);

  always_comb begin
    // Only the width bits matter for a store
    case (size[1:0])
      SZ_B[1:0]: begin
        lane_data = {4{wdata[7:0]}};  // Every lane carries the byte
        byte_en   = 4'b0001 << byte_off;
      end
      SZ_H[1:0]: begin
        lane_data = {2{wdata[15:0]}};
        byte_en   = byte_off[1] ? 4'b1100 : 4'b0011;  // Upper or lower half
      end
      SZ_W[1:0]: begin
        lane_data = wdata;
        byte_en   = 4'b1111;
      end
      default: begin
        lane_data = wdata;  // Code 3 is not a store size, treat as word
        byte_en   = 4'b1111;
      end
    endcase
  end

endmodule
